// ==== rtl/pad_pkg.sv ====
package pad_pkg;

	// Controller type codes as selected by the host menu
	typedef enum logic [2:0] {
		PAD_DIGITAL      = 3'd0,
		PAD_LGUN         = 3'd1,
		PAD_WHEEL        = 3'd2,
		PAD_MISSION      = 3'd3,
		PAD_3D           = 3'd4,
		PAD_DUAL_MISSION = 3'd5,
		PAD_MOUSE        = 3'd6,
		PAD_OFF          = 3'd7
	} pad_type_e;

	// Data nibble carried on pins 3..0
	typedef logic [3:0] nibble_t;

	// Button word from the host side, a 0 bit means pressed
	typedef logic [15:0] joy_word_t;

	// Signed analog axis as delivered by the host
	typedef logic [7:0] axis_t;

	// Handshake sequencer step
	typedef logic [4:0] seq_state_t;

	// Port pins seen as the TH/TR/TL handshake lines
	typedef struct packed {
		logic    th;
		logic    tr;
		logic    tl;
		nibble_t data;
	} pin_view_t;

	// The same pins as wired on the light gun connector
	typedef struct packed {
		logic    sensor_n;
		logic    start_n;
		logic    trig_n;
		nibble_t id;
	} lgun_view_t;

	typedef union packed {
		pin_view_t  pins;
		lgun_view_t lgun;
	} port_word_u;

	// Third nibble of a transfer identifies the pad
	localparam nibble_t ID_WHEEL   = 4'h3;
	localparam nibble_t ID_MISSION = 4'h5;
	localparam nibble_t ID_3D      = 4'h6;

	// First two nibbles of every transfer and the value left after an abort
	localparam nibble_t ACK_NIBBLE = 4'h1;

	localparam nibble_t LGUN_ID = 4'b1100;

	// Flips the sign bit so a signed axis reads as offset binary
	localparam nibble_t AXIS_BIAS = 4'h8;

	// Low bits of the digital pad identification nibble
	localparam logic [2:0] DIGITAL_ID_LOW = 3'b100;

	// Step reached after the final nibble of each sequenced pad
	localparam seq_state_t WHEEL_LAST   = 5'd10;
	localparam seq_state_t MISSION_LAST = 5'd14;
	localparam seq_state_t THREED_LAST  = 5'd16;

endpackage

// ==== rtl/three_wire_seq.sv ====
`timescale 1ns/1ns

module three_wire_seq (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                smpc_ce,
	input  pad_pkg::pad_type_e  pad_type,
	input  pad_pkg::port_word_u pdr_out,
	input  pad_pkg::joy_word_t  joy,
	input  pad_pkg::axis_t      axis_x,
	input  pad_pkg::axis_t      axis_y,
	output logic                tl,
	output pad_pkg::nibble_t    nibble,
	output logic                seq_drive
);
	import pad_pkg::*;

	seq_state_t step;
	seq_state_t last_step;
	seq_state_t next_step;
	seq_state_t nib_idx;
	logic       is_wheel;
	logic       want_tr;
	logic       abort;
	logic       advance;
	nibble_t    pad_id;
	nibble_t    next_nibble;

	// Only the three handshake pads run the sequencer
	always_comb begin
		seq_drive = 1'b0;
		last_step = '0;
		pad_id    = ID_MISSION;
		case (pad_type)
			PAD_WHEEL: begin
				seq_drive = 1'b1;
				last_step = WHEEL_LAST;
				pad_id    = ID_WHEEL;
			end
			PAD_MISSION: begin
				seq_drive = 1'b1;
				last_step = MISSION_LAST;
				pad_id    = ID_MISSION;
			end
			PAD_3D: begin
				seq_drive = 1'b1;
				last_step = THREED_LAST;
				pad_id    = ID_3D;
			end
			default: ;
		endcase
	end

	assign is_wheel = (pad_type == PAD_WHEEL);

	// Step 0 and the odd steps wait for TR high, the even steps for TR low
	assign want_tr = (step == '0) | step[0];

	// Steps 0 and 1 both send the first nibble and lead to step 2
	assign nib_idx   = (step == '0) ? '0 : step - 5'd1;
	assign next_step = (step == '0) ? 5'd2 : step + 5'd1;

	assign abort = pdr_out.pins.th & pdr_out.pins.tr;

	// A repeated TR level does not match want_tr again, so the step holds
	assign advance = ~pdr_out.pins.th
		& (pdr_out.pins.tr == want_tr)
		& (step < last_step);

	// Nibble presented for the step that is about to complete
	always_comb begin
		next_nibble = 4'h0;
		case (nib_idx)
			5'd0,
			5'd1: next_nibble = ACK_NIBBLE;
			5'd2: next_nibble = pad_id;
			5'd3: next_nibble = joy[15:12];
			5'd4: next_nibble = joy[11:8];
			5'd5: begin
				if (is_wheel) begin
					next_nibble = {1'b1, joy[6:4]};
				end else begin
					next_nibble = joy[7:4];
				end
			end
			5'd6: begin
				if (is_wheel) begin
					next_nibble = 4'hF;
				end else begin
					next_nibble = joy[3:0];
				end
			end
			5'd7: next_nibble = axis_x[7:4] ^ AXIS_BIAS;
			5'd8: next_nibble = axis_x[3:0];
			5'd9: next_nibble = axis_y[7:4] ^ AXIS_BIAS;
			5'd10: next_nibble = axis_y[3:0];
			// Unused third and fourth axis bytes read as zero except the 3D trailer
			5'd14: next_nibble = 4'h1;
			default: next_nibble = 4'h0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			step   <= '0;
			tl     <= 1'b1;
			nibble <= '0;
		end else if (smpc_ce && seq_drive) begin
			if (abort) begin
				// TH high with TR high restarts the transfer
				step   <= '0;
				tl     <= 1'b1;
				nibble <= ACK_NIBBLE;
			end else if (advance) begin
				step   <= next_step;
				tl     <= want_tr;
				nibble <= next_nibble;
			end
		end
	end

endmodule

// ==== rtl/pad_port.sv ====
`timescale 1ns/1ns

module pad_port (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                smpc_ce,
	input  pad_pkg::pad_type_e  pad_type,
	input  pad_pkg::port_word_u pdr_out,
	input  logic [6:0]          ddr,
	input  pad_pkg::joy_word_t  joy,
	input  pad_pkg::axis_t      axis_x,
	input  pad_pkg::axis_t      axis_y,
	input  logic                lgun_trig,
	input  logic                lgun_start,
	input  logic                lgun_sensor,
	output pad_pkg::port_word_u pdr_in
);
	import pad_pkg::*;

	logic    seq_tl;
	nibble_t seq_nibble;
	logic    seq_drive;
	nibble_t digital_id;

	three_wire_seq i_three_wire_seq (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce   (smpc_ce),
		.pad_type  (pad_type),
		.pdr_out   (pdr_out),
		.joy       (joy),
		.axis_x    (axis_x),
		.axis_y    (axis_y),
		.tl        (seq_tl),
		.nibble    (seq_nibble),
		.seq_drive (seq_drive)
	);

	assign digital_id = {joy[3], DIGITAL_ID_LOW};

	always_comb begin
		// Pins the host drives read back as written, the rest are pulled up
		pdr_in = (pdr_out & ddr) | ~ddr;

		case (pad_type)
			PAD_DIGITAL: begin
				if (ddr[6:5] == 2'b10) begin
					// Only TH is an output and selects between two nibbles
					if (pdr_out.pins.th) begin
						pdr_in.pins.data = digital_id;
					end else begin
						pdr_in.pins.data = joy[15:12];
					end
				end else if (ddr[6:5] == 2'b11) begin
					case ({pdr_out.pins.th, pdr_out.pins.tr})
						2'b00: pdr_in.pins.data = joy[7:4];
						2'b01: pdr_in.pins.data = joy[15:12];
						2'b10: pdr_in.pins.data = joy[11:8];
						default: pdr_in.pins.data = digital_id;
					endcase
				end
			end

			PAD_LGUN: begin
				// The gun owns all seven lines, so host writes are ignored here
				pdr_in.lgun.sensor_n = ~lgun_sensor;
				pdr_in.lgun.start_n  = ~lgun_start;
				pdr_in.lgun.trig_n   = ~lgun_trig;
				pdr_in.lgun.id       = LGUN_ID;
			end

			default: ;
		endcase

		// Handshake pads answer on TL and the data pins
		if (seq_drive) begin
			pdr_in.pins.tl   = seq_tl;
			pdr_in.pins.data = seq_nibble;
		end
	end

endmodule

// ==== rtl/saturn_pad_top.sv ====
`timescale 1ns/1ns

module saturn_pad_top (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                smpc_ce,

	input  pad_pkg::port_word_u pdr1_out,
	input  logic [6:0]          ddr1,
	output pad_pkg::port_word_u pdr1_in,
	input  pad_pkg::joy_word_t  joy1,
	input  pad_pkg::axis_t      joy1_x,
	input  pad_pkg::axis_t      joy1_y,
	input  pad_pkg::pad_type_e  joy1_type,
	input  logic                lgun1_trig,
	input  logic                lgun1_start,
	input  logic                lgun1_sensor,

	input  pad_pkg::port_word_u pdr2_out,
	input  logic [6:0]          ddr2,
	output pad_pkg::port_word_u pdr2_in,
	input  pad_pkg::joy_word_t  joy2,
	input  pad_pkg::axis_t      joy2_x,
	input  pad_pkg::axis_t      joy2_y,
	input  pad_pkg::pad_type_e  joy2_type,
	input  logic                lgun2_trig,
	input  logic                lgun2_start,
	input  logic                lgun2_sensor
);

	// Controller port 1
	pad_port i_port1 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.smpc_ce     (smpc_ce),
		.pad_type    (joy1_type),
		.pdr_out     (pdr1_out),
		.ddr         (ddr1),
		.joy         (joy1),
		.axis_x      (joy1_x),
		.axis_y      (joy1_y),
		.lgun_trig   (lgun1_trig),
		.lgun_start  (lgun1_start),
		.lgun_sensor (lgun1_sensor),
		.pdr_in      (pdr1_in)
	);

	// Controller port 2 shares no state with port 1
	pad_port i_port2 (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.smpc_ce     (smpc_ce),
		.pad_type    (joy2_type),
		.pdr_out     (pdr2_out),
		.ddr         (ddr2),
		.joy         (joy2),
		.axis_x      (joy2_x),
		.axis_y      (joy2_y),
		.lgun_trig   (lgun2_trig),
		.lgun_start  (lgun2_start),
		.lgun_sensor (lgun2_sensor),
		.pdr_in      (pdr2_in)
	);

endmodule

// ==== verification/tb_pad_model.svh ====
`ifndef TB_PAD_MODEL_SVH
`define TB_PAD_MODEL_SVH

// Values the pad is expected to place on the pins
localparam nibble_t ACK_EXP        = 4'h1;
localparam nibble_t WHEEL_ID_EXP   = 4'h3;
localparam nibble_t MISSION_ID_EXP = 4'h5;
localparam nibble_t THREED_ID_EXP  = 4'h6;
localparam nibble_t GUN_ID_EXP     = 4'hC;
localparam nibble_t AXIS_FLIP      = 4'h8;

// x^32 + x^22 + x^2 + x + 1 in right-shift Galois form
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(logic [31:0] state);
	if (state[0]) begin
		return (state >> 1) ^ LFSR_TAPS;
	end
	return state >> 1;
endfunction

// Read-back of a port whose pins are not taken over by the pad
function automatic port_word_u pulled_pins(port_word_u written, logic [6:0] dir);
	logic [6:0] bits;
	logic [6:0] raw;
	raw = written;
	for (int i = 0; i < 7; i++) begin
		bits[i] = dir[i] ? raw[i] : 1'b1;
	end
	return bits;
endfunction

// Expected read-back for the digital pad, the light gun and the pass-through codes
function automatic port_word_u expected_read(pad_type_e kind, port_word_u written,
	logic [6:0] dir, joy_word_t buttons, logic trig, logic start, logic sensor);
	port_word_u word;
	nibble_t    ident;
	word  = pulled_pins(written, dir);
	ident = {buttons[3], 3'b100};
	if (kind == PAD_DIGITAL) begin
		if (dir[6:5] == 2'b10) begin
			word.pins.data = written.pins.th ? ident : buttons[15:12];
		end else if (dir[6:5] == 2'b11) begin
			case ({written.pins.th, written.pins.tr})
				2'b00: word.pins.data = buttons[7:4];
				2'b01: word.pins.data = buttons[15:12];
				2'b10: word.pins.data = buttons[11:8];
				default: word.pins.data = ident;
			endcase
		end
	end else if (kind == PAD_LGUN) begin
		// Every gun line is active low on the connector
		word = {~sensor, ~start, ~trig, GUN_ID_EXP};
	end
	return word;
endfunction

function automatic int transfer_length(pad_type_e kind);
	case (kind)
		PAD_WHEEL: return 9;
		PAD_MISSION: return 13;
		PAD_3D: return 15;
		default: return 0;
	endcase
endfunction

// Nibble number index of a whole transfer for the given pad
function automatic nibble_t expected_nibble(pad_type_e kind, int index, joy_word_t buttons,
	axis_t x, axis_t y);
	nibble_t nibbles [$];
	nibble_t ident;
	case (kind)
		PAD_WHEEL: ident = WHEEL_ID_EXP;
		PAD_3D: ident = THREED_ID_EXP;
		default: ident = MISSION_ID_EXP;
	endcase
	nibbles.push_back(ACK_EXP);
	nibbles.push_back(ACK_EXP);
	nibbles.push_back(ident);
	nibbles.push_back(buttons[15:12]);
	nibbles.push_back(buttons[11:8]);
	if (kind == PAD_WHEEL) begin
		nibbles.push_back({1'b1, buttons[6:4]});
		nibbles.push_back(4'hF);
		nibbles.push_back(x[7:4] ^ AXIS_FLIP);
		nibbles.push_back(x[3:0]);
	end else begin
		nibbles.push_back(buttons[7:4]);
		nibbles.push_back(buttons[3:0]);
		nibbles.push_back(x[7:4] ^ AXIS_FLIP);
		nibbles.push_back(x[3:0]);
		nibbles.push_back(y[7:4] ^ AXIS_FLIP);
		nibbles.push_back(y[3:0]);
		nibbles.push_back(4'h0);
		nibbles.push_back(4'h0);
		// The 3D pad appends a two nibble trailer
		if (kind == PAD_3D) begin
			nibbles.push_back(4'h0);
			nibbles.push_back(4'h1);
		end
	end
	if (index < nibbles.size()) begin
		return nibbles[index];
	end
	return 4'h0;
endfunction

`endif

// ==== verification/tb_saturn_pad.sv ====
`timescale 1ns/1ns

module tb_saturn_pad;
	import pad_pkg::*;

	`include "tb_pad_model.svh"

	localparam int CLK_PERIOD    = 10;
	localparam int NUM_VECTORS   = 16;
	localparam int NUM_TRANSFERS = 5;
	localparam int ANSWER_LIMIT  = 20;
	// Digital vectors take eight cycles each and light gun vectors one
	localparam int COMB_CYCLES     = NUM_VECTORS * 9;
	localparam int WATCHDOG_CYCLES = NUM_TRANSFERS * 40 + COMB_CYCLES + 60;

	logic        CLK;
	logic        RST_N;
	logic        smpc_ce;
	port_word_u  pdr_out [1:2];
	logic [6:0]  ddr [1:2];
	port_word_u  pdr_in [1:2];
	joy_word_t   joy [1:2];
	axis_t       axis_x [1:2];
	axis_t       axis_y [1:2];
	pad_type_e   pad_type [1:2];
	logic        lgun_trig [1:2];
	logic        lgun_start [1:2];
	logic        lgun_sensor [1:2];
	logic [31:0] lfsr_state;

	saturn_pad_top i_saturn_pad_top (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.smpc_ce      (smpc_ce),
		.pdr1_out     (pdr_out[1]),
		.ddr1         (ddr[1]),
		.pdr1_in      (pdr_in[1]),
		.joy1         (joy[1]),
		.joy1_x       (axis_x[1]),
		.joy1_y       (axis_y[1]),
		.joy1_type    (pad_type[1]),
		.lgun1_trig   (lgun_trig[1]),
		.lgun1_start  (lgun_start[1]),
		.lgun1_sensor (lgun_sensor[1]),
		.pdr2_out     (pdr_out[2]),
		.ddr2         (ddr[2]),
		.pdr2_in      (pdr_in[2]),
		.joy2         (joy[2]),
		.joy2_x       (axis_x[2]),
		.joy2_y       (axis_y[2]),
		.joy2_type    (pad_type[2]),
		.lgun2_trig   (lgun_trig[2]),
		.lgun2_start  (lgun_start[2]),
		.lgun2_sensor (lgun_sensor[2])
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// Takes count bits from the LFSR, one step per bit
	function automatic logic [15:0] draw_bits(int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value      = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	task automatic check_port_word(input string name, input port_word_u actual,
		input port_word_u expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected);
			stop_run();
		end
	endtask

	task automatic check_nibble(input string name, input nibble_t actual, input nibble_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%01h, expected 0x%01h", name, actual, expected);
			stop_run();
		end
	endtask

	// Drives one vector on both ports at this falling edge and checks at the next one
	task automatic apply_digital(input logic [1:0] mode, input logic [1:0] pair);
		logic [15:0] bits;
		for (int p = 1; p <= 2; p++) begin
			bits       = draw_bits(5);
			ddr[p]     = {mode, bits[4:0]};
			bits       = draw_bits(5);
			pdr_out[p] = {pair ^ 2'(p - 1), bits[4:0]};
		end
		@(negedge CLK);
		for (int p = 1; p <= 2; p++) begin
			check_port_word($sformatf("pdr%0d_in", p), pdr_in[p], expected_read(pad_type[p],
				pdr_out[p], ddr[p], joy[p], lgun_trig[p], lgun_start[p], lgun_sensor[p]));
		end
	endtask

	task automatic apply_light_gun();
		logic [15:0] bits;
		for (int p = 1; p <= 2; p++) begin
			bits           = draw_bits(3);
			lgun_trig[p]   = bits[0];
			lgun_start[p]  = bits[1];
			lgun_sensor[p] = bits[2];
			bits           = draw_bits(7);
			ddr[p]         = {1'b1, bits[5:0]};
			bits           = draw_bits(7);
			pdr_out[p]     = bits[6:0];
			// Pin 6 driven to the wrong level must still read as the sensor line
			pdr_out[p].lgun.sensor_n = lgun_sensor[p];
		end
		@(negedge CLK);
		for (int p = 1; p <= 2; p++) begin
			check_port_word($sformatf("pdr%0d_in", p), pdr_in[p], expected_read(pad_type[p],
				pdr_out[p], ddr[p], joy[p], lgun_trig[p], lgun_start[p], lgun_sensor[p]));
		end
	endtask

	task automatic setup_sequenced(input int port, input pad_type_e kind);
		logic [15:0] bits;
		pad_type[port] = kind;
		ddr[port]      = 7'b110_0000;
		joy[port]      = draw_bits(16);
		bits           = draw_bits(8);
		axis_x[port]   = bits[7:0];
		bits           = draw_bits(8);
		axis_y[port]   = bits[7:0];
	endtask

	// Raises TH and TR and waits until the port shows the idle answer
	task automatic abort_transfer(input int port);
		int waited;
		pdr_out[port].pins.th = 1'b1;
		pdr_out[port].pins.tr = 1'b1;
		waited = 0;
		do begin
			@(negedge CLK);
			waited++;
		end while (!(pdr_in[port].pins.tl === 1'b1 && pdr_in[port].pins.data === ACK_EXP)
			&& waited < ANSWER_LIMIT);
		if (waited >= ANSWER_LIMIT) begin
			$display("Port %0d did not return to idle after a TH abort", port);
			stop_run();
		end
	endtask

	// Sets TR with TH low and reports whether TL followed within the limit
	task automatic toggle_tr(input int port, input logic level, output logic answered);
		int waited;
		pdr_out[port].pins.th = 1'b0;
		pdr_out[port].pins.tr = level;
		answered = 1'b0;
		waited   = 0;
		while (!answered && waited < ANSWER_LIMIT) begin
			@(negedge CLK);
			waited++;
			if (pdr_in[port].pins.tl === level) begin
				answered = 1'b1;
			end
		end
	endtask

	task automatic run_transfer(input int port, input int nibbles, input logic probe_end);
		int         other;
		logic       level;
		logic       answered;
		nibble_t    expect_nib;
		port_word_u other_before;
		other = (port == 1) ? 2 : 1;
		level = 1'b1;
		abort_transfer(port);
		other_before = pdr_in[other];
		for (int i = 0; i < nibbles; i++) begin
			level = (i % 2 == 0);
			toggle_tr(port, level, answered);
			if (!answered) begin
				$display("Port %0d gave no TL answer for nibble %0d", port, i);
				stop_run();
			end
			expect_nib = expected_nibble(pad_type[port], i, joy[port], axis_x[port], axis_y[port]);
			check_nibble($sformatf("pdr%0d_in.data", port), pdr_in[port].pins.data, expect_nib);
			check_port_word($sformatf("pdr%0d_in", port), pdr_in[port],
				{1'b0, level, level, expect_nib});
			check_port_word($sformatf("pdr%0d_in", other), pdr_in[other], other_before);
		end
		if (probe_end) begin
			// A finished pad ignores further toggles until the next abort
			toggle_tr(port, ~level, answered);
			if (answered) begin
				$display("Port %0d answered a toggle after its last nibble", port);
				stop_run();
			end
			check_nibble($sformatf("pdr%0d_in.data", port), pdr_in[port].pins.data, expect_nib);
		end
	endtask

	initial begin
		lfsr_state = 32'h9af5_13ea;
		CLK        = 1'b0;
		RST_N      = 1'b0;
		smpc_ce    = 1'b1;
		for (int p = 1; p <= 2; p++) begin
			pad_type[p]    = PAD_WHEEL;
			pdr_out[p]     = '0;
			ddr[p]         = '0;
			joy[p]         = '1;
			axis_x[p]      = '0;
			axis_y[p]      = '0;
			lgun_trig[p]   = 1'b0;
			lgun_start[p]  = 1'b0;
			lgun_sensor[p] = 1'b0;
		end
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);

		// Idle wheel ports read pulled-up TH and TR, TL high and a zero nibble
		for (int p = 1; p <= 2; p++) begin
			check_nibble($sformatf("pdr%0d_in.data", p), pdr_in[p].pins.data, 4'h0);
			check_port_word($sformatf("pdr%0d_in", p), pdr_in[p], 7'b111_0000);
		end

		pad_type[1] = PAD_DIGITAL;
		pad_type[2] = PAD_DIGITAL;
		for (int v = 0; v < NUM_VECTORS; v++) begin
			joy[1] = draw_bits(16);
			joy[2] = draw_bits(16);
			for (int pair = 0; pair < 4; pair++) begin
				apply_digital(2'b10, 2'(pair));
				apply_digital(2'b11, 2'(pair));
			end
		end

		pad_type[1] = PAD_LGUN;
		pad_type[2] = PAD_LGUN;
		for (int v = 0; v < NUM_VECTORS; v++) begin
			apply_light_gun();
		end

		setup_sequenced(1, PAD_WHEEL);
		run_transfer(1, transfer_length(PAD_WHEEL), 1'b1);
		setup_sequenced(2, PAD_MISSION);
		run_transfer(2, transfer_length(PAD_MISSION), 1'b1);
		setup_sequenced(1, PAD_3D);
		run_transfer(1, transfer_length(PAD_3D), 1'b0);

		// Abort a mission transfer halfway while port 2 holds a digital pad
		setup_sequenced(1, PAD_MISSION);
		pad_type[2] = PAD_DIGITAL;
		ddr[2]      = 7'b110_0000;
		joy[2]      = draw_bits(16);
		pdr_out[2]  = 7'b100_0000;
		run_transfer(1, 6, 1'b0);
		abort_transfer(1);
		check_port_word("pdr1_in", pdr_in[1], {3'b111, ACK_EXP});
		run_transfer(1, transfer_length(PAD_MISSION), 1'b0);
		check_port_word("pdr2_in", pdr_in[2], expected_read(pad_type[2], pdr_out[2], ddr[2],
			joy[2], lgun_trig[2], lgun_start[2], lgun_sensor[2]));

		$display("Simulation passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
		stop_run();
	end

endmodule

// ==== tb.f ====
+incdir+verification
rtl/pad_pkg.sv
rtl/three_wire_seq.sv
rtl/pad_port.sv
rtl/saturn_pad_top.sv
verification/tb_saturn_pad.sv

// ==== Makefile ====
# Verilator build, run and lint of the controller port testbench

TOP := tb_saturn_pad

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f tb.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ns --top-module $(TOP) -f tb.f
	verilator --lint-only --timescale 1ns/1ns --top-module saturn_pad_top \
		rtl/pad_pkg.sv rtl/three_wire_seq.sv rtl/pad_port.sv rtl/saturn_pad_top.sv

clean:
	rm -rf obj_dir
